// ==== Makefile ====
# Verilator lint and simulation of the controller testbench

VERILATOR ?= verilator
TOP       ?= cpuControlTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) common/ctrl_params.svh $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG); then \
		echo "Failure reported in $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/ctrlPkg.sv ====
// Controller types for opcodes, instruction classes, phases and ALU/shift control
`include "ctrl_params.svh"

package ctrlPkg;

    // Opcodes named by the instruction set
    typedef enum logic [`OP_WIDTH-1:0] {
        opTypeR = `OP_WIDTH'b000_000,
        opSram  = `OP_WIDTH'b000_001,
        opJ     = `OP_WIDTH'b000_010,
        opJal   = `OP_WIDTH'b000_011,
        opBeq   = `OP_WIDTH'b000_100,
        opBne   = `OP_WIDTH'b000_101,
        opBle   = `OP_WIDTH'b000_110,
        opBgt   = `OP_WIDTH'b000_111,
        opAddi  = `OP_WIDTH'b001_000,
        opAddiu = `OP_WIDTH'b001_001,
        opSlti  = `OP_WIDTH'b001_010,
        opLui   = `OP_WIDTH'b001_111,
        opLb    = `OP_WIDTH'b100_000,
        opLh    = `OP_WIDTH'b100_001,
        opLw    = `OP_WIDTH'b100_011,
        opSb    = `OP_WIDTH'b101_000,
        opSh    = `OP_WIDTH'b101_001,
        opRt    = `OP_WIDTH'b101_011
    } opcodeT;

    // R-type funct codes
    typedef enum logic [`OP_WIDTH-1:0] {
        fnSll   = `OP_WIDTH'b000_000,
        fnSrl   = `OP_WIDTH'b000_010,
        fnSra   = `OP_WIDTH'b000_011,
        fnSllv  = `OP_WIDTH'b000_100,
        fnDivm  = `OP_WIDTH'b000_101,
        fnSrav  = `OP_WIDTH'b000_111,
        fnJr    = `OP_WIDTH'b001_000,
        fnBreak = `OP_WIDTH'b001_101,
        fnMfhi  = `OP_WIDTH'b010_000,
        fnMflo  = `OP_WIDTH'b010_010,
        fnRte   = `OP_WIDTH'b010_011,
        fnMult  = `OP_WIDTH'b011_000,
        fnDiv   = `OP_WIDTH'b011_010,
        fnAdd   = `OP_WIDTH'b100_000,
        fnSub   = `OP_WIDTH'b100_010,
        fnAnd   = `OP_WIDTH'b100_100,
        fnSlt   = `OP_WIDTH'b101_010
    } functT;

    typedef enum logic [1:0] {
        execArith,
        execShift,
        execPassThrough,
        execIllegal
    } execClassT;

    typedef enum logic [2:0] {
        phReset,
        phFetch,
        phDecode,
        phExec,
        phOverflow,
        phOpError
    } phaseT;

    typedef enum logic [1:0] {
        shLeft,
        shRightLogical,
        shRightArith
    } shiftKindT;

    // Zero means no ALU operation requested
    typedef enum logic [`ALU_OP_WIDTH-1:0] {
        aluAdd = `ALU_OP_WIDTH'd1,
        aluSub = `ALU_OP_WIDTH'd2
    } aluOpT;

endpackage

// ==== common/ctrl_params.svh ====
// Controller widths and datapath select codes
`ifndef CTRL_PARAMS_SVH
`define CTRL_PARAMS_SVH

// Field and control widths
`define OP_WIDTH          6
`define STEP_WIDTH        2
`define ALU_OP_WIDTH      3
`define SEL_WIDTH         2
`define WD_SEL_WIDTH      3
`define SHIFT_CTRL_WIDTH  3

// Register file write address select
`define WR_SEL_RT     `SEL_WIDTH'd0
`define WR_SEL_RD     `SEL_WIDTH'd1
`define WR_SEL_STACK  `SEL_WIDTH'd3

// Register file write data select
`define WD_SEL_ALUOUT `WD_SEL_WIDTH'd0
`define WD_SEL_SHIFT  `WD_SEL_WIDTH'd5
`define WD_SEL_STACK  `WD_SEL_WIDTH'd6

`endif

// ==== control/controlEncoder.sv ====
// Control encoder registering the datapath controls for each phase and step
`timescale 1ns/1ps
`include "ctrl_params.svh"

module controlEncoder (
    input  logic                         clk,
    input  logic                         arstN,
    input  ctrlPkg::phaseT               phase,
    input  logic [`STEP_WIDTH-1:0]       step,
    input  ctrlPkg::execClassT           latClass,
    input  logic                         latUseImm,
    input  logic                         latIsSub,
    input  logic                         latWriteRt,
    input  logic                         latShiftVar,
    input  ctrlPkg::shiftKindT           latShiftKind,
    output logic                         pcWrite,
    output logic                         irWrite,
    output logic                         memRead,
    output logic                         loadAb,
    output logic                         aluOutLoad,
    output logic                         regWrite,
    output logic [`SEL_WIDTH-1:0]        aluSrcA,
    output logic [`SEL_WIDTH-1:0]        aluSrcB,
    output logic [`SEL_WIDTH-1:0]        wrReg,
    output logic [`SEL_WIDTH-1:0]        shiftIn,
    output logic [`SEL_WIDTH-1:0]        shiftS,
    output logic [`WD_SEL_WIDTH-1:0]     wdReg,
    output ctrlPkg::aluOpT               aluOp,
    output logic [`SHIFT_CTRL_WIDTH-1:0] shiftCtrl
);

    import ctrlPkg::*;

    // Shifter operation code per kind
    function automatic logic [`SHIFT_CTRL_WIDTH-1:0] shiftCode(input shiftKindT kind);
        case (kind)
            shRightLogical: shiftCode = `SHIFT_CTRL_WIDTH'd3;
            shRightArith:   shiftCode = `SHIFT_CTRL_WIDTH'd4;
            default:        shiftCode = `SHIFT_CTRL_WIDTH'd2;
        endcase
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcWrite    <= 1'b0;
            irWrite    <= 1'b0;
            memRead    <= 1'b0;
            loadAb     <= 1'b0;
            aluOutLoad <= 1'b0;
            regWrite   <= 1'b0;
            aluSrcA    <= '0;
            aluSrcB    <= '0;
            wrReg      <= '0;
            shiftIn    <= '0;
            shiftS     <= '0;
            wdReg      <= '0;
            aluOp      <= aluOpT'(0);
            shiftCtrl  <= '0;
        end else begin
            pcWrite    <= 1'b0;
            irWrite    <= 1'b0;
            memRead    <= 1'b0;
            loadAb     <= 1'b0;
            aluOutLoad <= 1'b0;
            regWrite   <= 1'b0;
            aluSrcA    <= '0;
            aluSrcB    <= '0;
            wrReg      <= '0;
            shiftIn    <= '0;
            shiftS     <= '0;
            wdReg      <= '0;
            aluOp      <= aluOpT'(0);
            shiftCtrl  <= '0;

            case (phase)
                // Initialise the stack pointer register
                phReset: begin
                    regWrite <= 1'b1;
                    wrReg    <= `WR_SEL_STACK;
                    wdReg    <= `WD_SEL_STACK;
                end
                phFetch: begin
                    if (step == `STEP_WIDTH'd3) begin
                        pcWrite <= 1'b1;
                        irWrite <= 1'b1;
                    end else begin
                        // Memory read while the ALU computes PC + 4
                        memRead <= 1'b1;
                        aluSrcB <= `SEL_WIDTH'd1;
                        aluOp   <= aluAdd;
                    end
                end
                phDecode: begin
                    if (step == `STEP_WIDTH'd0) begin
                        // Branch target precomputed into ALUOut
                        aluSrcB    <= `SEL_WIDTH'd3;
                        aluOp      <= aluAdd;
                        aluOutLoad <= 1'b1;
                    end else begin
                        loadAb <= 1'b1;
                    end
                end
                phExec: begin
                    if (latClass == execArith) begin
                        if (step == `STEP_WIDTH'd0) begin
                            aluSrcA    <= `SEL_WIDTH'd2;
                            aluSrcB    <= latUseImm ? `SEL_WIDTH'd2 : `SEL_WIDTH'd0;
                            aluOp      <= latIsSub ? aluSub : aluAdd;
                            aluOutLoad <= 1'b1;
                        end else if (step == `STEP_WIDTH'd2) begin
                            regWrite <= 1'b1;
                            wrReg    <= latWriteRt ? `WR_SEL_RT : `WR_SEL_RD;
                            wdReg    <= `WD_SEL_ALUOUT;
                        end
                    end else if (latClass == execShift) begin
                        if (step == `STEP_WIDTH'd0) begin
                            // Load shifter with B and the shift amount source
                            shiftIn   <= latShiftVar ? `SEL_WIDTH'd0 : `SEL_WIDTH'd2;
                            shiftS    <= latShiftVar ? `SEL_WIDTH'd0 : `SEL_WIDTH'd1;
                            shiftCtrl <= `SHIFT_CTRL_WIDTH'd1;
                        end else if (step == `STEP_WIDTH'd1) begin
                            shiftCtrl <= shiftCode(latShiftKind);
                        end else begin
                            regWrite <= 1'b1;
                            wrReg    <= `WR_SEL_RD;
                            wdReg    <= `WD_SEL_SHIFT;
                        end
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

// ==== control/instrDecoder.sv ====
// Instruction decoder mapping opcode and funct to an execution class and its variant
`timescale 1ns/1ps
`include "ctrl_params.svh"

module instrDecoder (
    input  logic [`OP_WIDTH-1:0] op,
    input  logic [`OP_WIDTH-1:0] funct,
    output ctrlPkg::execClassT   execClass,
    output logic                 useImm,
    output logic                 isSub,
    output logic                 writeRt,
    output logic                 shiftVar,
    output ctrlPkg::shiftKindT   shiftKind
);

    import ctrlPkg::*;

    always_comb begin
        execClass = execIllegal;
        useImm    = 1'b0;
        isSub     = 1'b0;
        writeRt   = 1'b0;
        shiftVar  = 1'b0;
        shiftKind = shLeft;

        if (opcodeT'(op) == opTypeR) begin
            case (functT'(funct))
                fnAdd: begin
                    execClass = execArith;
                end
                fnSub: begin
                    execClass = execArith;
                    isSub     = 1'b1;
                end
                fnSll: begin
                    execClass = execShift;
                end
                fnSrl: begin
                    execClass = execShift;
                    shiftKind = shRightLogical;
                end
                fnSra: begin
                    execClass = execShift;
                    shiftKind = shRightArith;
                end
                // Shift amount taken from rs
                fnSllv: begin
                    execClass = execShift;
                    shiftVar  = 1'b1;
                end
                fnSrav: begin
                    execClass = execShift;
                    shiftVar  = 1'b1;
                    shiftKind = shRightArith;
                end
                fnAnd, fnDiv, fnMult, fnJr, fnMfhi, fnMflo, fnSlt,
                fnBreak, fnRte, fnDivm: begin
                    execClass = execPassThrough;
                end
                default: begin
                    execClass = execIllegal;
                end
            endcase
        end else begin
            case (opcodeT'(op))
                // Immediate operand, result goes to rt
                opAddi: begin
                    execClass = execArith;
                    useImm    = 1'b1;
                    writeRt   = 1'b1;
                end
                opAddiu, opBeq, opBne, opBle, opBgt, opSram, opLb, opLh,
                opLui, opLw, opSb, opSh, opSlti, opRt, opJ, opJal: begin
                    execClass = execPassThrough;
                end
                default: begin
                    execClass = execIllegal;
                end
            endcase
        end
    end

endmodule

// ==== control/phaseSequencer.sv ====
// Phase sequencer stepping through reset, fetch, decode and execute of each instruction
`timescale 1ns/1ps
`include "ctrl_params.svh"

module phaseSequencer (
    input  logic                   clk,
    input  logic                   arstN,
    input  ctrlPkg::execClassT     execClass,
    input  logic                   useImm,
    input  logic                   isSub,
    input  logic                   writeRt,
    input  logic                   shiftVar,
    input  ctrlPkg::shiftKindT     shiftKind,
    input  logic                   overflow,
    output ctrlPkg::phaseT         phase,
    output logic [`STEP_WIDTH-1:0] step,
    output ctrlPkg::execClassT     latClass,
    output logic                   latUseImm,
    output logic                   latIsSub,
    output logic                   latWriteRt,
    output logic                   latShiftVar,
    output ctrlPkg::shiftKindT     latShiftKind
);

    import ctrlPkg::*;

    logic [`STEP_WIDTH-1:0] stepQ;
    logic [`STEP_WIDTH-1:0] nextStep;
    phaseT                  nextPhase;
    logic                   decodeDone;
    logic                   commitStep;

    assign decodeDone = (phase == phDecode) && (stepQ == `STEP_WIDTH'd1);

    always_comb begin
        nextPhase = phase;
        nextStep  = stepQ + `STEP_WIDTH'd1;

        case (phase)
            phFetch: begin
                if (stepQ == `STEP_WIDTH'd3) begin
                    nextPhase = phDecode;
                    nextStep  = '0;
                end
            end
            phDecode: begin
                if (decodeDone) begin
                    nextPhase = (execClass == execIllegal) ? phOpError : phExec;
                    nextStep  = '0;
                end
            end
            phExec: begin
                case (latClass)
                    // Overflow seen on the second cycle diverts to phOverflow
                    execArith: begin
                        if (stepQ == `STEP_WIDTH'd1) begin
                            nextPhase = overflow ? phOverflow : phFetch;
                            nextStep  = '0;
                        end
                    end
                    execShift: begin
                        if (stepQ == `STEP_WIDTH'd2) begin
                            nextPhase = phFetch;
                            nextStep  = '0;
                        end
                    end
                    default: begin
                        nextPhase = phFetch;
                        nextStep  = '0;
                    end
                endcase
            end
            // Reset, overflow and opcode error all last one cycle
            default: begin
                nextPhase = phFetch;
                nextStep  = '0;
            end
        endcase
    end

    // Second arithmetic cycle shown as step 2 when the result is written back
    assign commitStep = (phase == phExec) && (latClass == execArith) &&
                        (stepQ == `STEP_WIDTH'd1) && (nextPhase != phOverflow);
    assign step = commitStep ? `STEP_WIDTH'd2 : stepQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            phase <= phReset;
            stepQ <= '0;
        end else begin
            phase <= nextPhase;
            stepQ <= nextStep;
        end
    end

    // Instruction fields held through execute
    always_ff @(posedge clk) begin
        if (decodeDone) begin
            latClass     <= execClass;
            latUseImm    <= useImm;
            latIsSub     <= isSub;
            latWriteRt   <= writeRt;
            latShiftVar  <= shiftVar;
            latShiftKind <= shiftKind;
        end
    end

endmodule

// ==== list.f ====
+incdir+common
common/ctrlPkg.sv
control/instrDecoder.sv
control/phaseSequencer.sv
control/controlEncoder.sv
src/cpuControl.sv
tb/cpuControlTb.sv

// ==== src/cpuControl.sv ====
// Multicycle processor controller built from decoder, sequencer and encoder
`timescale 1ns/1ps
`include "ctrl_params.svh"

module cpuControl (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic [`OP_WIDTH-1:0]         op,
    input  logic [`OP_WIDTH-1:0]         funct,
    input  logic                         overflow,
    output logic                         pcWrite,
    output logic                         irWrite,
    output logic                         memRead,
    output logic                         loadAb,
    output logic                         aluOutLoad,
    output logic                         regWrite,
    output logic [`SEL_WIDTH-1:0]        aluSrcA,
    output logic [`SEL_WIDTH-1:0]        aluSrcB,
    output logic [`SEL_WIDTH-1:0]        wrReg,
    output logic [`SEL_WIDTH-1:0]        shiftIn,
    output logic [`SEL_WIDTH-1:0]        shiftS,
    output logic [`WD_SEL_WIDTH-1:0]     wdReg,
    output ctrlPkg::aluOpT               aluOp,
    output logic [`SHIFT_CTRL_WIDTH-1:0] shiftCtrl
);

    import ctrlPkg::*;

    execClassT              execClass;
    logic                   useImm;
    logic                   isSub;
    logic                   writeRt;
    logic                   shiftVar;
    shiftKindT              shiftKind;
    phaseT                  phase;
    logic [`STEP_WIDTH-1:0] step;
    execClassT              latClass;
    logic                   latUseImm;
    logic                   latIsSub;
    logic                   latWriteRt;
    logic                   latShiftVar;
    shiftKindT              latShiftKind;

    instrDecoder uDecoder (
        .op        (op),
        .funct     (funct),
        .execClass (execClass),
        .useImm    (useImm),
        .isSub     (isSub),
        .writeRt   (writeRt),
        .shiftVar  (shiftVar),
        .shiftKind (shiftKind)
    );

    phaseSequencer uSequencer (
        .clk          (clk),
        .arstN        (arstN),
        .execClass    (execClass),
        .useImm       (useImm),
        .isSub        (isSub),
        .writeRt      (writeRt),
        .shiftVar     (shiftVar),
        .shiftKind    (shiftKind),
        .overflow     (overflow),
        .phase        (phase),
        .step         (step),
        .latClass     (latClass),
        .latUseImm    (latUseImm),
        .latIsSub     (latIsSub),
        .latWriteRt   (latWriteRt),
        .latShiftVar  (latShiftVar),
        .latShiftKind (latShiftKind)
    );

    controlEncoder uEncoder (
        .clk          (clk),
        .arstN        (arstN),
        .phase        (phase),
        .step         (step),
        .latClass     (latClass),
        .latUseImm    (latUseImm),
        .latIsSub     (latIsSub),
        .latWriteRt   (latWriteRt),
        .latShiftVar  (latShiftVar),
        .latShiftKind (latShiftKind),
        .pcWrite      (pcWrite),
        .irWrite      (irWrite),
        .memRead      (memRead),
        .loadAb       (loadAb),
        .aluOutLoad   (aluOutLoad),
        .regWrite     (regWrite),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .wrReg        (wrReg),
        .shiftIn      (shiftIn),
        .shiftS       (shiftS),
        .wdReg        (wdReg),
        .aluOp        (aluOp),
        .shiftCtrl    (shiftCtrl)
    );

endmodule

// ==== tb/cpuControlTb.sv ====
// Self-checking testbench for the multicycle processor controller
`timescale 1ns/1ps
`include "ctrl_params.svh"

module cpuControlTb;

    import ctrlPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_TESTS    = 40;
    // Opcodes the instruction set leaves unnamed
    localparam logic [`OP_WIDTH-1:0] UNNAMED_OPS [0:9] = '{
        6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h10, 6'h1f, 6'h22, 6'h24, 6'h30, 6'h3f
    };

    logic                         clk;
    logic                         arstN;
    logic [`OP_WIDTH-1:0]         op;
    logic [`OP_WIDTH-1:0]         funct;
    logic                         overflow;
    logic                         pcWrite;
    logic                         irWrite;
    logic                         memRead;
    logic                         loadAb;
    logic                         aluOutLoad;
    logic                         regWrite;
    logic [`SEL_WIDTH-1:0]        aluSrcA;
    logic [`SEL_WIDTH-1:0]        aluSrcB;
    logic [`SEL_WIDTH-1:0]        wrReg;
    logic [`SEL_WIDTH-1:0]        shiftIn;
    logic [`SEL_WIDTH-1:0]        shiftS;
    logic [`WD_SEL_WIDTH-1:0]     wdReg;
    aluOpT                        aluOp;
    logic [`SHIFT_CTRL_WIDTH-1:0] shiftCtrl;

    // One byte per field: op, funct, ovf, interval, writes, wrReg, wdReg, aluOp,
    // shift code, shiftIn, shiftS
    logic [87:0] testMem [0:MAX_TESTS-1];
    logic [5:0]  lineCount;
    logic [5:0]  testIdx;
    int          errors;
    int          testsRun;
    int          testsOk;
    int          cycleCount = 0;
    int          cycleLimit;

    cpuControl uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: no instruction boundary within %0d cycles", cycleLimit);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic reportError(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic compareField(input string name, input string what,
                                input logic [7:0] got, input logic [7:0] expected);
        if (got !== expected) begin
            reportError($sformatf("%s: %s is %0d, expected %0d", name, what, got, expected));
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testsRun++;
        if (errors == errorsBefore) begin
            testsOk++;
            $display("Test %0d %s: ok", testsRun, name);
        end else begin
            $display("Test %0d %s: %0d mismatches", testsRun, name, errors - errorsBefore);
        end
    endtask

    function automatic logic outputsActive();
        return |{pcWrite, irWrite, memRead, loadAb, aluOutLoad, regWrite, aluSrcA,
                 aluSrcB, wrReg, shiftIn, shiftS, wdReg, aluOp, shiftCtrl};
    endfunction

    // Called at the rising edge that releases reset
    task automatic checkResetSequence(input string name);
        int         errorsBefore;
        logic       irSeen;
        logic [7:0] cycles;
        logic [7:0] reads;
        errorsBefore = errors;
        // Sequencer leaves phReset one edge after release
        repeat (2) @(negedge clk);
        compareField(name, "reset regWrite", 8'(regWrite), 8'd1);
        compareField(name, "reset wrReg", 8'(wrReg), 8'(`WR_SEL_STACK));
        compareField(name, "reset wdReg", 8'(wdReg), 8'(`WD_SEL_STACK));
        cycles = '0;
        reads  = '0;
        irSeen = 1'b0;
        while (!irSeen) begin
            @(negedge clk);
            cycles = cycles + 8'd1;
            // Memory read while the ALU adds 4 to the PC
            if (memRead && aluSrcB == `SEL_WIDTH'd1 && aluOp == aluAdd) begin
                reads = reads + 8'd1;
            end
            irSeen = irWrite;
        end
        compareField(name, "fetch length", cycles, 8'd4);
        compareField(name, "memRead cycles", reads, 8'd3);
        compareField(name, "pcWrite", 8'(pcWrite), 8'd1);
        finishTest(name, errorsBefore);
    endtask

    // Starts right after an irWrite pulse and ends at the next one
    task automatic runInstruction(input logic [5:0] idx);
        logic [87:0]                  line;
        logic [`OP_WIDTH-1:0]         opVal;
        logic [3:0]                   pick;
        string                        name;
        int                           errorsBefore;
        logic                         irSeen;
        logic [7:0]                   cycles;
        logic [7:0]                   writes;
        logic [7:0]                   loads;
        logic [7:0]                   aluLoads;
        logic [7:0]                   seenWrReg;
        logic [7:0]                   seenWdReg;
        logic [7:0]                   seenAluOp;
        logic [7:0]                   seenSrcB;
        logic [7:0]                   seenCode;
        logic [7:0]                   seenShiftIn;
        logic [7:0]                   seenShiftS;
        logic [7:0]                   expSrcB;
        logic [7:0]                   expAluLoads;
        logic [`SHIFT_CTRL_WIDTH-1:0] prevShift;
        line         = testMem[idx];
        errorsBefore = errors;
        opVal        = line[85:80];
        if (line[87:80] == 8'h80) begin
            pick  = 4'($urandom % 10);
            opVal = UNNAMED_OPS[pick];
        end
        name = $sformatf("op=%h funct=%h ovf=%0b", opVal, line[77:72], line[64]);
        // ADDI takes its second operand from the immediate
        expSrcB = (opVal == `OP_WIDTH'h08) ? 8'd2 : 8'd0;
        // Arithmetic loads ALUOut again in its first execute cycle
        expAluLoads = (line[31:24] != 8'd0) ? 8'd2 : 8'd1;
        @(posedge clk);
        op       <= opVal;
        funct    <= line[77:72];
        overflow <= line[64];
        cycles      = '0;
        writes      = '0;
        loads       = '0;
        aluLoads    = '0;
        seenWrReg   = '0;
        seenWdReg   = '0;
        seenAluOp   = '0;
        seenSrcB    = '0;
        seenCode    = '0;
        seenShiftIn = '0;
        seenShiftS  = '0;
        prevShift   = '0;
        irSeen      = 1'b0;
        while (!irSeen) begin
            @(negedge clk);
            cycles = cycles + 8'd1;
            if (cycles == 8'd1 &&
                !(aluOutLoad && aluSrcB == `SEL_WIDTH'd3 && aluOp == aluAdd)) begin
                reportError($sformatf("%s: first decode cycle lacks the target add", name));
            end
            if (regWrite) begin
                writes    = writes + 8'd1;
                seenWrReg = 8'(wrReg);
                seenWdReg = 8'(wdReg);
            end
            if (loadAb) begin
                loads = loads + 8'd1;
            end
            if (aluOutLoad) begin
                aluLoads = aluLoads + 8'd1;
            end
            // Only the first arithmetic cycle selects A from the register
            if (aluSrcA == `SEL_WIDTH'd2) begin
                seenAluOp = 8'(aluOp);
                seenSrcB  = 8'(aluSrcB);
            end
            if (shiftCtrl == `SHIFT_CTRL_WIDTH'd1) begin
                seenShiftIn = 8'(shiftIn);
                seenShiftS  = 8'(shiftS);
            end
            if (prevShift == `SHIFT_CTRL_WIDTH'd1) begin
                seenCode = 8'(shiftCtrl);
            end
            prevShift = shiftCtrl;
            irSeen    = irWrite;
        end
        compareField(name, "irWrite interval", cycles, line[63:56]);
        compareField(name, "regWrite count", writes, line[55:48]);
        compareField(name, "wrReg", seenWrReg, line[47:40]);
        compareField(name, "wdReg", seenWdReg, line[39:32]);
        compareField(name, "aluOp", seenAluOp, line[31:24]);
        compareField(name, "aluSrcB", seenSrcB, expSrcB);
        compareField(name, "loadAb count", loads, 8'd1);
        compareField(name, "aluOutLoad count", aluLoads, expAluLoads);
        compareField(name, "pcWrite", 8'(pcWrite), 8'd1);
        compareField(name, "shift code", seenCode, line[23:16]);
        compareField(name, "shiftIn", seenShiftIn, line[15:8]);
        compareField(name, "shiftS", seenShiftS, line[7:0]);
        finishTest(name, errorsBefore);
    endtask

    task automatic checkMidReset();
        int errorsBefore;
        errorsBefore = errors;
        // ADD, interrupted in decode
        @(posedge clk);
        op       <= `OP_WIDTH'h00;
        funct    <= `OP_WIDTH'h20;
        overflow <= 1'b0;
        @(negedge clk);
        @(posedge clk);
        arstN <= 1'b0;
        @(negedge clk);
        if (outputsActive()) begin
            reportError("control outputs still active during asynchronous reset");
        end
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        finishTest("asynchronous reset in decode", errorsBefore);
        checkResetSequence("restart after mid-instruction reset");
    endtask

    initial begin
        void'($urandom(97907));
        arstN      = 1'b0;
        op         = '0;
        funct      = '0;
        overflow   = 1'b0;
        errors     = 0;
        testsRun   = 0;
        testsOk    = 0;
        cycleLimit = 0;
        $readmemh("tb/cpuControl_testdata.txt", testMem);
        lineCount = '0;
        while (lineCount < 6'(MAX_TESTS) && testMem[lineCount][87:80] != 8'hff) begin
            lineCount = lineCount + 6'd1;
        end
        cycleLimit = 12 * int'(lineCount) + 20;

        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
        checkResetSequence("reset write after power-on");
        for (testIdx = '0; testIdx < lineCount; testIdx = testIdx + 6'd1) begin
            runInstruction(testIdx);
        end
        checkMidReset();

        $display("Summary: %0d tests, %0d ok, %0d with mismatches, %0d errors",
                 testsRun, testsOk, testsRun - testsOk, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb/cpuControl_testdata.txt ====
// op_funct_ovf_interval_writes_wrReg_wdReg_aluOp_shiftCode_shiftIn_shiftS, hex bytes
// op 80 picks a random unnamed opcode, op ff ends the list
00_20_00_08_01_01_00_01_00_00_00  // ADD
00_22_00_08_01_01_00_02_00_00_00  // SUB
08_00_00_08_01_00_00_01_00_00_00  // ADDI
08_3f_00_08_01_00_00_01_00_00_00  // ADDI, funct ignored
00_20_01_09_00_00_00_01_00_00_00  // ADD with overflow
00_22_01_09_00_00_00_02_00_00_00  // SUB with overflow
08_00_01_09_00_00_00_01_00_00_00  // ADDI with overflow
00_00_00_09_01_01_05_00_02_02_01  // SLL
00_02_00_09_01_01_05_00_03_02_01  // SRL
00_03_00_09_01_01_05_00_04_02_01  // SRA
00_04_00_09_01_01_05_00_02_00_00  // SLLV
00_07_00_09_01_01_05_00_04_00_00  // SRAV
00_03_01_09_01_01_05_00_04_02_01  // SRA, overflow has no effect
00_24_00_07_00_00_00_00_00_00_00  // AND
00_1a_00_07_00_00_00_00_00_00_00  // DIV
00_18_00_07_00_00_00_00_00_00_00  // MULT
00_08_00_07_00_00_00_00_00_00_00  // JR
00_2a_00_07_00_00_00_00_00_00_00  // SLT
04_00_00_07_00_00_00_00_00_00_00  // BEQ
23_00_00_07_00_00_00_00_00_00_00  // LW
2b_00_00_07_00_00_00_00_00_00_00  // store word slot
02_00_00_07_00_00_00_00_00_00_00  // J
0f_00_00_07_00_00_00_00_00_00_00  // LUI
09_00_00_07_00_00_00_00_00_00_00  // ADDIU
00_01_00_07_00_00_00_00_00_00_00  // unnamed funct
00_3f_00_07_00_00_00_00_00_00_00  // unnamed funct
00_21_00_07_00_00_00_00_00_00_00  // unnamed funct
0b_00_00_07_00_00_00_00_00_00_00  // unnamed opcode
80_00_00_07_00_00_00_00_00_00_00  // random unnamed opcode
80_00_00_07_00_00_00_00_00_00_00  // random unnamed opcode
80_00_00_07_00_00_00_00_00_00_00  // random unnamed opcode
00_20_00_08_01_01_00_01_00_00_00  // ADD after opcode errors
ff_00_00_00_00_00_00_00_00_00_00  // end of list
